//--- include/cache_axi_cfg.svh
// beats are 4 bytes wide and LINE_WORDS must equal 2**BEAT_W since the beat index wraps
`ifndef CACHE_AXI_CFG_SVH
`define CACHE_AXI_CFG_SVH

// byte address width
`define CACHE_AXI_ADDR_W 32

// one AXI beat
`define CACHE_AXI_DATA_W 32

// words per line, also beats per burst
`define CACHE_AXI_LINE_WORDS 8

`define CACHE_AXI_BEAT_W 3 // log2 of line words

`endif

//--- src/cache_axi_pkg.sv
// shared types for one cache port with the line size fixed by cache_axi_cfg.svh
`default_nettype none

`include "cache_axi_cfg.svh"

package cache_axi_pkg;

    // same bits seen as one vector or as bus words
    typedef union packed {
        logic [`CACHE_AXI_LINE_WORDS*`CACHE_AXI_DATA_W-1:0]     flat;
        logic [`CACHE_AXI_LINE_WORDS-1:0][`CACHE_AXI_DATA_W-1:0] words;
    } line_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        FINISH
    } refill_state_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_state_t;

endpackage

`default_nettype wire

//--- src/refill_reader.sv
// assumes the slave returns exactly one line of incrementing beats per read burst
`timescale 1ns/1ns
`default_nettype none

`include "cache_axi_cfg.svh"

module refill_reader import cache_axi_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rd_req,
    input  logic [`CACHE_AXI_ADDR_W-1:0] rd_addr,
    input  logic                         arready,
    input  logic                         rvalid,
    input  logic                         rlast,
    input  logic [`CACHE_AXI_DATA_W-1:0] rdata,
    output logic [`CACHE_AXI_ADDR_W-1:0] araddr,
    output logic                         arvalid,
    output logic                         rready,
    output logic                         beat_valid,
    output logic [`CACHE_AXI_BEAT_W-1:0] beat_index,
    output logic [`CACHE_AXI_DATA_W-1:0] beat_data,
    output logic                         finish
);

    refill_state_t                state_q;
    refill_state_t                state_d;
    logic [`CACHE_AXI_ADDR_W-1:0] addr_q;
    logic [`CACHE_AXI_BEAT_W-1:0] beat_cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:    if (rd_req) state_d = REQ;
            REQ:     if (arready) state_d = WAIT;
            WAIT:    if (rvalid && rlast) state_d = FINISH;
            FINISH:  state_d = IDLE; // one cycle for the return strobe
            default: state_d = IDLE;
        endcase
    end

    // request address, taken only when the request is accepted
    always_ff @(posedge clk) begin
        if (state_q == IDLE && rd_req) begin
            addr_q <= rd_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt_q <= '0;
        end else if (arvalid && arready) begin
            beat_cnt_q <= '0;
        end else if (beat_valid) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    assign araddr     = addr_q;
    assign arvalid    = (state_q == REQ);
    assign rready     = (state_q == WAIT);
    assign beat_valid = rvalid && rready;
    assign beat_index = beat_cnt_q;
    assign beat_data  = rdata;
    assign finish     = (state_q == FINISH);

endmodule

`default_nettype wire

//--- src/line_assembler.sv
// ret_line keeps the last refilled line until the next refill overwrites it word by word
`timescale 1ns/1ns
`default_nettype none

`include "cache_axi_cfg.svh"

module line_assembler import cache_axi_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         beat_valid,
    input  logic [`CACHE_AXI_BEAT_W-1:0] beat_index,
    input  logic [`CACHE_AXI_DATA_W-1:0] beat_data,
    input  logic                         finish,
    output line_t                        ret_line,
    output logic                         ret_valid
);

    line_t line_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_q.flat <= '0;
        end else if (beat_valid) begin
            line_q.words[beat_index] <= beat_data; // slot picked by beat order
        end
    end

    // last beat was written on the edge that entered FINISH
    assign ret_valid     = finish;
    assign ret_line.flat = line_q.flat;

endmodule

`default_nettype wire

//--- src/writeback_buffer.sv
// holds one dirty line and a request arriving while busy is dropped
`timescale 1ns/1ns
`default_nettype none

`include "cache_axi_cfg.svh"

module writeback_buffer import cache_axi_pkg::*; (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             wr_req,
    input  logic [`CACHE_AXI_ADDR_W-1:0]                     wr_addr,
    input  logic [`CACHE_AXI_LINE_WORDS*`CACHE_AXI_DATA_W-1:0] wr_line,
    input  logic                                             done,
    output logic                                             wr_busy,
    output logic                                             start,
    output logic [`CACHE_AXI_ADDR_W-1:0]                     wb_addr,
    output line_t                                            wb_line
);

    logic busy_q;

    assign start = wr_req && !busy_q; // writer leaves idle on the capture edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    // stays stable for the whole burst
    always_ff @(posedge clk) begin
        if (start) begin
            wb_addr      <= wr_addr;
            wb_line.flat <= wr_line;
        end
    end

    assign wr_busy = busy_q;

endmodule

`default_nettype wire

//--- src/writeback_writer.sv
// writes one full line per burst and ignores the write response code
`timescale 1ns/1ns
`default_nettype none

`include "cache_axi_cfg.svh"

module writeback_writer import cache_axi_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [`CACHE_AXI_ADDR_W-1:0] wb_addr,
    input  line_t                        wb_line,
    input  logic                         awready,
    input  logic                         wready,
    input  logic                         bvalid,
    output logic [`CACHE_AXI_ADDR_W-1:0] awaddr,
    output logic                         awvalid,
    output logic [`CACHE_AXI_DATA_W-1:0] wdata,
    output logic                         wlast,
    output logic                         wvalid,
    output logic                         bready,
    output logic                         done
);

    localparam logic [`CACHE_AXI_BEAT_W-1:0] LAST_IDX = '1; // line words is a power of two

    wb_state_t                    state_q;
    wb_state_t                    state_d;
    logic [`CACHE_AXI_BEAT_W-1:0] idx_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            WB_IDLE: if (start) state_d = WB_ADDR;
            WB_ADDR: if (awready) state_d = WB_DATA;
            WB_DATA: if (wready && wlast) state_d = WB_RESP;
            WB_RESP: if (bvalid) state_d = WB_IDLE;
            default: state_d = WB_IDLE;
        endcase
    end

    // word index for the W channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (awvalid && awready) begin
            idx_q <= '0;
        end else if (wvalid && wready) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign awaddr  = wb_addr;
    assign awvalid = (state_q == WB_ADDR);
    assign wvalid  = (state_q == WB_DATA);
    assign wdata   = wb_line.words[idx_q];
    assign wlast   = wvalid && (idx_q == LAST_IDX);
    assign bready  = (state_q == WB_RESP);
    assign done    = bready && bvalid; // buffer drops busy on the next edge

endmodule

`default_nettype wire

//--- src/cache_axi_bridge.sv
// single cache port with fixed INCR bursts of one line and 4-byte beats, no ids or resp
`timescale 1ns/1ns
`default_nettype none

`include "cache_axi_cfg.svh"

module cache_axi_bridge import cache_axi_pkg::*; (
    input  logic                                               clk,
    input  logic                                               rst_n,
    // cache side
    input  logic                                               rd_req,
    input  logic [`CACHE_AXI_ADDR_W-1:0]                       rd_addr,
    output logic                                               ret_valid,
    output logic [`CACHE_AXI_LINE_WORDS*`CACHE_AXI_DATA_W-1:0] ret_line,
    input  logic                                               wr_req,
    input  logic [`CACHE_AXI_ADDR_W-1:0]                       wr_addr,
    input  logic [`CACHE_AXI_LINE_WORDS*`CACHE_AXI_DATA_W-1:0] wr_line,
    output logic                                               wr_busy,
    // AXI side
    output logic [`CACHE_AXI_ADDR_W-1:0]                       araddr,
    output logic                                               arvalid,
    input  logic                                               arready,
    input  logic [`CACHE_AXI_DATA_W-1:0]                       rdata,
    input  logic                                               rlast,
    input  logic                                               rvalid,
    output logic                                               rready,
    output logic [`CACHE_AXI_ADDR_W-1:0]                       awaddr,
    output logic                                               awvalid,
    input  logic                                               awready,
    output logic [`CACHE_AXI_DATA_W-1:0]                       wdata,
    output logic                                               wlast,
    output logic                                               wvalid,
    input  logic                                               wready,
    input  logic                                               bvalid,
    output logic                                               bready
);

    logic                         beat_valid;
    logic [`CACHE_AXI_BEAT_W-1:0] beat_index;
    logic [`CACHE_AXI_DATA_W-1:0] beat_data;
    logic                         finish;
    line_t                        ret_line_w;
    logic                         start;
    logic [`CACHE_AXI_ADDR_W-1:0] wb_addr;
    line_t                        wb_line;
    logic                         done;

    // read path
    refill_reader u_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rdata      (rdata),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .rready     (rready),
        .beat_valid (beat_valid),
        .beat_index (beat_index),
        .beat_data  (beat_data),
        .finish     (finish)
    );

    line_assembler u_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat_index (beat_index),
        .beat_data  (beat_data),
        .finish     (finish),
        .ret_line   (ret_line_w),
        .ret_valid  (ret_valid)
    );

    assign ret_line = ret_line_w.flat;

    // writeback path, independent of the read path
    writeback_buffer u_wb_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .wr_addr (wr_addr),
        .wr_line (wr_line),
        .done    (done),
        .wr_busy (wr_busy),
        .start   (start),
        .wb_addr (wb_addr),
        .wb_line (wb_line)
    );

    writeback_writer u_wb_writer (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .wb_addr (wb_addr),
        .wb_line (wb_line),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .wdata   (wdata),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .bready  (bready),
        .done    (done)
    );

endmodule

`default_nettype wire

//--- test/tb_cache_axi_bridge.sv
// slave model holds 1 KB, table lines must be aligned below 0x380 which is kept for the dropped request
`timescale 1ns/1ns
`default_nettype none

`include "cache_axi_cfg.svh"

module tb_cache_axi_bridge;

    localparam int AW      = `CACHE_AXI_ADDR_W;
    localparam int DW      = `CACHE_AXI_DATA_W;
    localparam int N_WORDS = `CACHE_AXI_LINE_WORDS;
    localparam int LINE_W  = N_WORDS * DW;
    localparam int N_TESTS = 8;
    localparam logic [7:0]    LAST_BEAT  = 8'(N_WORDS - 1);
    localparam logic [AW-1:0] SPARE_ADDR = 'h380; // only the dropped request targets it

    // op (1 = writeback), line address, fill pattern
    localparam logic [64:0] TESTS [N_TESTS] = '{
        {1'b0, 32'h0000_0000, 32'h0000_0000},
        {1'b1, 32'h0000_0040, 32'ha5a5_0000},
        {1'b0, 32'h0000_0040, 32'h0000_0000},
        {1'b0, 32'h0000_01e0, 32'h0000_0000},
        {1'b1, 32'h0000_0100, 32'h5eed_1000},
        {1'b1, 32'h0000_0000, 32'hc0de_0100},
        {1'b0, 32'h0000_0000, 32'h0000_0000},
        {1'b0, 32'h0000_0100, 32'h0000_0000}
    };

    logic              clk;
    logic              rst_n;
    logic              rd_req;
    logic [AW-1:0]     rd_addr;
    logic              ret_valid;
    logic [LINE_W-1:0] ret_line;
    logic              wr_req;
    logic [AW-1:0]     wr_addr;
    logic [LINE_W-1:0] wr_line;
    logic              wr_busy;
    logic [AW-1:0]     araddr;
    logic              arvalid, arready, rvalid, rready, rlast;
    logic [DW-1:0]     rdata;
    logic [AW-1:0]     awaddr;
    logic              awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [DW-1:0]     wdata;

    logic [DW-1:0] mem [256];     // slave memory, word index is addr[9:2]
    logic [DW-1:0] ref_mem [256]; // expected contents
    logic [15:0]   lfsr;
    logic [AW-1:0] rd_base;
    logic [AW-1:0] wr_base;
    logic [AW-1:0] exp_araddr;
    logic [AW-1:0] exp_awaddr;
    logic [7:0]    rd_beat;
    logic [7:0]    wr_beat;
    logic          rd_active;
    logic          b_pending;
    int            ar_count;
    int            beat_count;
    int            b_count;
    logic [64:0]   entry;
    string         test_name;

    cache_axi_bridge dut (.*);

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11
    endfunction

    function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] a);
        return a ^ {a[15:0], 16'hc3a5};
    endfunction

    function automatic logic [LINE_W-1:0] pattern_line(input logic [DW-1:0] pat);
        logic [LINE_W-1:0] l;
        for (int k = 0; k < N_WORDS; k++) begin
            l[k*DW +: DW] = pat + DW'(k);
        end
        return l;
    endfunction

    function automatic logic [LINE_W-1:0] slave_line(input logic [AW-1:0] addr);
        logic [LINE_W-1:0] l;
        for (int k = 0; k < N_WORDS; k++) begin
            l[k*DW +: DW] = mem[addr[9:2] + 8'(k)];
        end
        return l;
    endfunction

    function automatic logic [LINE_W-1:0] model_line(input logic [AW-1:0] addr);
        logic [LINE_W-1:0] l;
        for (int k = 0; k < N_WORDS; k++) begin
            l[k*DW +: DW] = ref_mem[addr[9:2] + 8'(k)];
        end
        return l;
    endfunction

    task automatic check(input string name, input logic [LINE_W-1:0] expected,
                         input logic [LINE_W-1:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (N_TESTS * N_WORDS * 40) @(posedge clk);
        $display("watchdog expired: a transfer never completed, the bridge hung");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    // AXI slave, judges handshakes mid-cycle and drives 1 ns after the edge
    initial begin
        arready    = 1'b0;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rdata      = '0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        rd_base    = '0;
        wr_base    = '0;
        rd_beat    = '0;
        wr_beat    = '0;
        rd_active  = 1'b0;
        b_pending  = 1'b0;
        ar_count   = 0;
        beat_count = 0;
        b_count    = 0;
        lfsr       = 16'd2541;
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = fill_word(AW'(i * 4));
        end
        forever begin
            @(negedge clk); // these values are what the next edge takes
            if (arvalid && arready) begin
                check({test_name, " araddr"}, LINE_W'(exp_araddr), LINE_W'(araddr));
                rd_base   = araddr;
                rd_beat   = '0;
                rd_active = 1'b1;
                ar_count++;
            end
            if (rvalid && rready) begin
                beat_count++;
                rd_beat = rd_beat + 8'd1;
                if (rlast) begin
                    rd_active = 1'b0;
                end
            end
            if (awvalid && awready) begin
                check({test_name, " awaddr"}, LINE_W'(exp_awaddr), LINE_W'(awaddr));
                wr_base = awaddr;
                wr_beat = '0;
            end
            if (wvalid && wready) begin
                check($sformatf("%s wlast on beat %0d", test_name, wr_beat),
                      LINE_W'(wr_beat == LAST_BEAT), LINE_W'(wlast));
                mem[wr_base[9:2] + wr_beat] = wdata;
                wr_beat = wr_beat + 8'd1;
                if (wlast) begin
                    b_pending = 1'b1;
                end
            end
            if (bvalid && bready) begin
                check({test_name, " wr_busy at bvalid"}, LINE_W'(1), LINE_W'(wr_busy));
                b_count++;
                b_pending = 1'b0;
            end
            @(posedge clk);
            #1;
            lfsr    = lfsr_step(lfsr);
            arready = lfsr[0];
            lfsr    = lfsr_step(lfsr);
            rvalid  = rd_active && lfsr[0]; // random gaps between beats
            rdata   = mem[rd_base[9:2] + rd_beat];
            rlast   = (rd_beat == LAST_BEAT);
            lfsr    = lfsr_step(lfsr);
            awready = lfsr[0];
            lfsr    = lfsr_step(lfsr);
            wready  = lfsr[0];
            if (b_pending && !bvalid) begin
                lfsr   = lfsr_step(lfsr);
                bvalid = lfsr[0];
            end else begin
                bvalid = b_pending; // held until taken
            end
        end
    end

    task automatic request_refill(input logic [AW-1:0] addr);
        int bursts_before;
        int beats_before;
        bursts_before = ar_count;
        beats_before  = beat_count;
        exp_araddr    = addr;
        rd_addr       = addr;
        rd_req        = 1'b1;
        @(posedge clk);
        #1 rd_req = 1'b0;
        @(negedge clk);
        while (!ret_valid) @(negedge clk);
        check({test_name, " ret_line"}, model_line(addr), ret_line);
        check({test_name, " accepted beats"}, LINE_W'(N_WORDS),
              LINE_W'(beat_count - beats_before));
        check({test_name, " read bursts"}, LINE_W'(1), LINE_W'(ar_count - bursts_before));
        @(negedge clk);
        check({test_name, " ret_valid width"}, '0, LINE_W'(ret_valid));
        @(posedge clk);
        #1;
    endtask

    task automatic send_writeback(input logic [AW-1:0] addr, input logic [DW-1:0] pat);
        logic [LINE_W-1:0] line;
        int                resp_before;
        line        = pattern_line(pat);
        resp_before = b_count;
        exp_awaddr  = addr;
        wr_addr     = addr;
        wr_line     = line;
        wr_req      = 1'b1;
        @(posedge clk);
        #1;
        wr_addr = SPARE_ADDR; // request held while busy, must be dropped
        wr_line = ~line;
        @(negedge clk);
        check({test_name, " wr_busy after capture"}, LINE_W'(1), LINE_W'(wr_busy));
        @(posedge clk);
        #1 wr_req = 1'b0;
        @(negedge clk);
        while (wr_busy) @(negedge clk);
        check({test_name, " written line"}, line, slave_line(addr));
        check({test_name, " dropped request"}, model_line(SPARE_ADDR), slave_line(SPARE_ADDR));
        check({test_name, " write responses"}, LINE_W'(1), LINE_W'(b_count - resp_before));
        for (int k = 0; k < N_WORDS; k++) begin
            ref_mem[addr[9:2] + 8'(k)] = line[k*DW +: DW];
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n     = 1'b0;
        rd_req    = 1'b0;
        rd_addr   = '0;
        wr_req    = 1'b0;
        wr_addr   = '0;
        wr_line   = '0;
        test_name = "reset";
        for (int i = 0; i < 256; i++) begin
            ref_mem[8'(i)] = fill_word(AW'(i * 4));
        end
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check("after reset", '0,
              LINE_W'({arvalid, rready, awvalid, wvalid, wlast, bready, ret_valid, wr_busy}));
        @(posedge clk);
        #1;
        for (int t = 0; t < N_TESTS; t++) begin
            entry = TESTS[3'(t)];
            if (entry[64]) begin
                test_name = $sformatf("test %0d writeback 0x%0h", t, entry[63:32]);
                send_writeback(entry[63:32], entry[31:0]);
            end else begin
                test_name = $sformatf("test %0d refill 0x%0h", t, entry[63:32]);
                request_refill(entry[63:32]);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_axi_bridge.f
+incdir+include
src/cache_axi_pkg.sv
src/refill_reader.sv
src/line_assembler.sv
src/writeback_buffer.sv
src/writeback_writer.sv
src/cache_axi_bridge.sv
test/tb_cache_axi_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the cache AXI bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -j 0 --top-module tb_cache_axi_bridge -f cache_axi_bridge.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_cache_axi_bridge > "$log" 2>&1
status=$?
cat "$log"

if grep -q "ERRORS FOUND" "$log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
